//--- Bender.yml
package:
  name: rename_core

sources:
  - include_dirs:
      - design
    files:
      - design/rename_pkg.sv
      - design/rename_table.sv
      - design/free_list.sv
      - design/reorder_buffer.sv
      - design/retire_table.sv
      - design/rename_core.sv
  - target: simulation
    files:
      - sim/rename_core_sva.sv
      - sim/rename_core_tb.sv

//--- design/free_list.sv
`timescale 1ns/10ps

`include "rename_params.svh"

module free_list
import rename_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      alloc,
    output phys_reg_t free_reg,
    input  logic      retire,
    input  logic      retire_alloc,
    input  phys_reg_t returned_reg,
    input  logic      flush
);

localparam int FREE_REGS = `RENAME_PHYS_REGS - `RENAME_ARCH_REGS;
localparam int IDX_MSB   = $bits(free_ptr_t) - 2;

phys_reg_t queue [FREE_REGS];

// Speculative head, committed head and tail of the queue
free_ptr_t alloc_ptr;
free_ptr_t retire_ptr;
free_ptr_t write_ptr;

logic      give_back;
free_ptr_t retire_ptr_next;

// Only a committed instruction that took a register hands one back
assign give_back       = retire && retire_alloc;
assign retire_ptr_next = give_back ? retire_ptr + 1'b1 : retire_ptr;

assign free_reg = queue[alloc_ptr[IDX_MSB:0]];

always_ff @(posedge clk) begin
    if (rst) begin
        // Queue starts full with every register above the arch range
        for (int i = 0; i < FREE_REGS; i++) begin
            queue[i] <= phys_reg_t'(`RENAME_ARCH_REGS + i);
        end
        alloc_ptr  <= '0;
        retire_ptr <= '0;
        write_ptr  <= free_ptr_t'(FREE_REGS);
    end else begin
        if (give_back) begin
            queue[write_ptr[IDX_MSB:0]] <= returned_reg;
            write_ptr  <= write_ptr + 1'b1;
            retire_ptr <= retire_ptr_next;
        end
        // Rewind includes a commit landing in the flush cycle
        if (flush) begin
            alloc_ptr <= retire_ptr_next;
        end else if (alloc) begin
            alloc_ptr <= alloc_ptr + 1'b1;
        end
    end
end

endmodule : free_list

//--- design/rename_core.sv
`timescale 1ns/10ps

`include "rename_params.svh"

module rename_core
import rename_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      dispatch_valid,
    input  arch_reg_t arch_rd,
    input  arch_reg_t arch_rs1,
    input  arch_reg_t arch_rs2,
    output logic      rename_valid,
    output phys_reg_t phys_rs1,
    output phys_reg_t phys_rs2,
    output phys_reg_t phys_rd,
    output rob_id_t   rob_id,
    output logic      rob_full,
    input  logic      complete_valid,
    input  rob_id_t   complete_id,
    input  logic      flush,
    output logic      commit_valid,
    output arch_reg_t commit_arch_rd,
    output phys_reg_t commit_phys_rd,
    output phys_reg_t freed_reg,
    output logic      freed_valid
);

phys_reg_t lookup_rs1, lookup_rs2, old_phys_rd, free_reg;
phys_reg_t restore_map [`RENAME_ARCH_REGS];
logic      accepted, alloc;
rob_id_t   alloc_id;

rename_table rename_table_i (
    .clk(clk), .rst(rst), .alloc(alloc), .arch_rd(arch_rd), .new_phys_rd(free_reg),
    .arch_rs1(arch_rs1), .arch_rs2(arch_rs2),
    .phys_rs1(lookup_rs1), .phys_rs2(lookup_rs2), .old_phys_rd(old_phys_rd),
    .flush(flush), .restore_map(restore_map)
);

// Freed registers come straight from the commit outputs
free_list free_list_i (
    .clk(clk), .rst(rst), .alloc(alloc), .free_reg(free_reg),
    .retire(commit_valid), .retire_alloc(freed_valid), .returned_reg(freed_reg),
    .flush(flush)
);

reorder_buffer reorder_buffer_i (
    .clk(clk), .rst(rst), .dispatch_valid(dispatch_valid), .arch_rd(arch_rd),
    .phys_rd(free_reg), .old_phys_rd(old_phys_rd),
    .accepted(accepted), .alloc(alloc), .rob_id(alloc_id), .rob_full(rob_full),
    .complete_valid(complete_valid), .complete_id(complete_id), .flush(flush),
    .commit_valid(commit_valid), .commit_arch_rd(commit_arch_rd),
    .commit_phys_rd(commit_phys_rd), .freed_reg(freed_reg), .freed_valid(freed_valid)
);

retire_table retire_table_i (
    .clk(clk), .rst(rst), .commit_valid(commit_valid), .commit_arch_rd(commit_arch_rd),
    .commit_phys_rd(commit_phys_rd), .freed_valid(freed_valid), .restore_map(restore_map)
);

// Rename result, one cycle after dispatch
always_ff @(posedge clk) begin
    if (rst) begin
        rename_valid <= 1'b0;
    end else begin
        rename_valid <= accepted;
    end
end

always_ff @(posedge clk) begin
    if (accepted) begin
        phys_rs1 <= lookup_rs1;
        phys_rs2 <= lookup_rs2;
        phys_rd  <= alloc ? free_reg : '0;
        rob_id   <= alloc_id;
    end
end

endmodule : rename_core

//--- design/rename_params.svh
`ifndef RENAME_PARAMS_SVH
`define RENAME_PARAMS_SVH

// Architectural registers seen by the instruction set
`define RENAME_ARCH_REGS 32

// Physical registers behind the alias tables
`define RENAME_PHYS_REGS 64

// In-flight instructions tracked by the reorder buffer
`define RENAME_ROB_DEPTH 8

`endif

//--- design/rename_pkg.sv
`include "rename_params.svh"

package rename_pkg;

// Register and slot indices
typedef logic [$clog2(`RENAME_ARCH_REGS)-1:0] arch_reg_t;
typedef logic [$clog2(`RENAME_PHYS_REGS)-1:0] phys_reg_t;
typedef logic [$clog2(`RENAME_ROB_DEPTH)-1:0] rob_id_t;

// Free list pointer, one wrap bit above the queue index
typedef logic [$clog2(`RENAME_PHYS_REGS - `RENAME_ARCH_REGS):0] free_ptr_t;

endpackage : rename_pkg

//--- design/rename_table.sv
`timescale 1ns/10ps

`include "rename_params.svh"

module rename_table
import rename_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      alloc,
    input  arch_reg_t arch_rd,
    input  phys_reg_t new_phys_rd,
    input  arch_reg_t arch_rs1,
    input  arch_reg_t arch_rs2,
    output phys_reg_t phys_rs1,
    output phys_reg_t phys_rs2,
    output phys_reg_t old_phys_rd,
    input  logic      flush,
    input  phys_reg_t restore_map [`RENAME_ARCH_REGS]
);

// Speculative mapping, one entry per architectural register
phys_reg_t map [`RENAME_ARCH_REGS];

always_ff @(posedge clk) begin
    if (rst) begin
        // Identity mapping out of reset
        for (int i = 0; i < `RENAME_ARCH_REGS; i++) begin
            map[i] <= phys_reg_t'(i);
        end
    end else if (flush) begin
        for (int i = 0; i < `RENAME_ARCH_REGS; i++) begin
            map[i] <= restore_map[i];
        end
    end else if (alloc) begin
        map[arch_rd] <= new_phys_rd;
    end
end

// Lookups see the table before this instruction's own rd write
assign phys_rs1    = map[arch_rs1];
assign phys_rs2    = map[arch_rs2];
assign old_phys_rd = map[arch_rd];

endmodule : rename_table

//--- design/reorder_buffer.sv
`timescale 1ns/10ps

`include "rename_params.svh"

module reorder_buffer
import rename_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      dispatch_valid,
    input  arch_reg_t arch_rd,
    input  phys_reg_t phys_rd,
    input  phys_reg_t old_phys_rd,
    output logic      accepted,
    output logic      alloc,
    output rob_id_t   rob_id,
    output logic      rob_full,
    input  logic      complete_valid,
    input  rob_id_t   complete_id,
    input  logic      flush,
    output logic      commit_valid,
    output arch_reg_t commit_arch_rd,
    output phys_reg_t commit_phys_rd,
    output phys_reg_t freed_reg,
    output logic      freed_valid
);

// Per-slot payload
arch_reg_t arch_rd_q  [`RENAME_ROB_DEPTH];
phys_reg_t phys_rd_q  [`RENAME_ROB_DEPTH];
phys_reg_t old_phys_q [`RENAME_ROB_DEPTH];
logic [`RENAME_ROB_DEPTH-1:0] done_q;

rob_id_t head;
rob_id_t tail;
logic [$clog2(`RENAME_ROB_DEPTH):0] count;

logic fire;

assign rob_full = (count == ($clog2(`RENAME_ROB_DEPTH) + 1)'(`RENAME_ROB_DEPTH));
assign accepted = dispatch_valid && !rob_full && !flush;
// x0 never takes a register
assign alloc    = accepted && (arch_rd != '0);
assign rob_id   = tail;

// Head retires once done, never in a flush cycle
assign fire = (count != '0) && done_q[head] && !flush;

always_ff @(posedge clk) begin
    if (rst || flush) begin
        head  <= '0;
        tail  <= '0;
        count <= '0;
    end else begin
        if (accepted) begin
            tail <= tail + 1'b1;
        end
        if (fire) begin
            head <= head + 1'b1;
        end
        case ({accepted, fire})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
        endcase
    end
end

always_ff @(posedge clk) begin
    if (rst) begin
        done_q <= '0;
    end else begin
        if (accepted) begin
            done_q[tail] <= 1'b0;
        end
        if (complete_valid) begin
            done_q[complete_id] <= 1'b1;
        end
    end
end

always_ff @(posedge clk) begin
    if (accepted) begin
        arch_rd_q[tail]  <= arch_rd;
        phys_rd_q[tail]  <= alloc ? phys_rd : '0;
        old_phys_q[tail] <= old_phys_rd;
    end
end

// Commit strobes
always_ff @(posedge clk) begin
    if (rst) begin
        commit_valid <= 1'b0;
        freed_valid  <= 1'b0;
    end else begin
        commit_valid <= fire;
        freed_valid  <= fire && (arch_rd_q[head] != '0);
    end
end

always_ff @(posedge clk) begin
    if (fire) begin
        commit_arch_rd <= arch_rd_q[head];
        commit_phys_rd <= phys_rd_q[head];
        freed_reg      <= old_phys_q[head];
    end
end

endmodule : reorder_buffer

//--- design/retire_table.sv
`timescale 1ns/10ps

`include "rename_params.svh"

module retire_table
import rename_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      commit_valid,
    input  arch_reg_t commit_arch_rd,
    input  phys_reg_t commit_phys_rd,
    input  logic      freed_valid,
    output phys_reg_t restore_map [`RENAME_ARCH_REGS]
);

// Committed mapping
phys_reg_t map [`RENAME_ARCH_REGS];

logic write_en;

assign write_en = commit_valid && freed_valid;

always_ff @(posedge clk) begin
    if (rst) begin
        for (int i = 0; i < `RENAME_ARCH_REGS; i++) begin
            map[i] <= phys_reg_t'(i);
        end
    end else if (write_en) begin
        map[commit_arch_rd] <= commit_phys_rd;
    end
end

// Pending commit shows through so a same-cycle flush restores it too
always_comb begin
    for (int i = 0; i < `RENAME_ARCH_REGS; i++) begin
        restore_map[i] = map[i];
    end
    if (write_en) begin
        restore_map[commit_arch_rd] = commit_phys_rd;
    end
end

endmodule : retire_table

//--- sim/rename_core_sva.sv
`timescale 1ns/10ps

module rename_core_sva (
    input logic clk,
    input logic rst,
    input logic dispatch_valid,
    input logic rob_full,
    input logic flush,
    input logic rename_valid,
    input logic commit_valid,
    input logic freed_valid
);

int failures = 0;

logic accepted;

assign accepted = dispatch_valid && !rob_full && !flush;

// One rename result per accepted dispatch, one cycle later
rename_after_accept: assert property (@(posedge clk) disable iff (rst)
    accepted |=> rename_valid)
    else begin
        $error("rename_valid missing after an accepted dispatch");
        failures++;
    end

rename_only_after_accept: assert property (@(posedge clk) disable iff (rst)
    rename_valid |-> $past(accepted))
    else begin
        $error("rename_valid without an accepted dispatch");
        failures++;
    end

// Flush suppresses the commit that was about to fire
no_commit_after_flush: assert property (@(posedge clk) disable iff (rst)
    flush |=> !commit_valid)
    else begin
        $error("commit_valid in the cycle after flush");
        failures++;
    end

freed_needs_commit: assert property (@(posedge clk) disable iff (rst)
    freed_valid |-> commit_valid)
    else begin
        $error("freed_valid without commit_valid");
        failures++;
    end

endmodule : rename_core_sva

bind rename_core rename_core_sva rename_core_sva_i (.*);

//--- sim/rename_core_tb.sv
`timescale 1ns/10ps

module rename_core_tb
import rename_pkg::*;
();

localparam int WAIT_CYCLES = 100;

typedef struct packed {
    phys_reg_t rs1;
    phys_reg_t rs2;
    phys_reg_t rd;
    rob_id_t   id;
} rename_rec_t;

typedef struct packed {
    arch_reg_t rd;
    phys_reg_t prd;
    phys_reg_t freed;
    logic      fv;
} commit_rec_t;

logic      clk;
logic      rst;
logic      dispatch_valid;
arch_reg_t arch_rd, arch_rs1, arch_rs2;
logic      rename_valid;
phys_reg_t phys_rs1, phys_rs2, phys_rd;
rob_id_t   rob_id;
logic      rob_full;
logic      complete_valid;
rob_id_t   complete_id;
logic      flush;
logic      commit_valid;
arch_reg_t commit_arch_rd;
phys_reg_t commit_phys_rd, freed_reg;
logic      freed_valid;

rename_rec_t rename_q [$];
commit_rec_t commit_q [$];
int    checks, errors, test_errors, tests;
bit    aborted;
string test_name;

rename_core rename_core_i (.*);

initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
end

// Outputs sampled mid-cycle, away from the rising edge
always @(negedge clk) begin
    if (!rst && rename_valid) begin
        rename_q.push_back({phys_rs1, phys_rs2, phys_rd, rob_id});
    end
    if (!rst && commit_valid) begin
        commit_q.push_back({commit_arch_rd, commit_phys_rd, freed_reg, freed_valid});
    end
end

task automatic next_cycle();
    @(posedge clk);
    #1;
endtask

task automatic check_value(string name, int got, int exp);
    checks++;
    assert (got == exp) else begin
        $display("error at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
        test_errors++;
    end
endtask

task automatic await_record(bit commit, string what);
    int waited;
    waited = 0;
    while ((commit ? commit_q.size() : rename_q.size()) == 0 && waited < WAIT_CYCLES) begin
        next_cycle();
        waited++;
    end
    checks++;
    assert ((commit ? commit_q.size() : rename_q.size()) != 0) else begin
        $display("timeout: no %s within %0d cycles, at %0t ns", what, WAIT_CYCLES, $time);
        test_errors++;
        aborted = 1'b1;
    end
endtask

task automatic dispatch(int rd, int rs1, int rs2, int e_rs1, int e_rs2, int e_rd, int e_id);
    rename_rec_t rec;
    dispatch_valid = 1'b1;
    arch_rd        = arch_reg_t'(rd);
    arch_rs1       = arch_reg_t'(rs1);
    arch_rs2       = arch_reg_t'(rs2);
    next_cycle();
    dispatch_valid = 1'b0;
    await_record(1'b0, "rename_valid");
    if (!aborted) begin
        rec = rename_q.pop_front();
        check_value("phys_rs1", rec.rs1, e_rs1);
        check_value("phys_rs2", rec.rs2, e_rs2);
        check_value("phys_rd", rec.rd, e_rd);
        check_value("rob_id", rec.id, e_id);
    end
endtask

// Rename result is due one cycle after the dispatch edge
task automatic dispatch_ignored(int rd, int rs1, int rs2);
    dispatch_valid = 1'b1;
    arch_rd        = arch_reg_t'(rd);
    arch_rs1       = arch_reg_t'(rs1);
    arch_rs2       = arch_reg_t'(rs2);
    next_cycle();
    dispatch_valid = 1'b0;
    next_cycle();
    checks++;
    assert (rename_q.size() == 0) else begin
        $display("dispatch made while rob_full was high got a rename result, at %0t ns", $time);
        test_errors++;
        rename_q.delete();
    end
endtask

task automatic complete(int id);
    complete_valid = 1'b1;
    complete_id    = rob_id_t'(id);
    next_cycle();
    complete_valid = 1'b0;
    repeat ($urandom % 3) begin
        next_cycle();
    end
endtask

task automatic expect_commit(int rd, int prd, int freed, int fv);
    commit_rec_t rec;
    await_record(1'b1, "commit_valid");
    if (!aborted) begin
        rec = commit_q.pop_front();
        check_value("commit_arch_rd", rec.rd, rd);
        check_value("commit_phys_rd", rec.prd, prd);
        check_value("freed_reg", rec.freed, freed);
        check_value("freed_valid", rec.fv, fv);
    end
endtask

// Dependent writes of one rd, each reading the previous destination
task automatic dispatch_chain(int n, int rd, int src, int dest, int id, bit retire);
    int prev;
    prev = src;
    for (int k = 0; k < n && !aborted; k++) begin
        dispatch(rd, rd, rd, prev, prev, dest + k, rob_id_t'(id + k));
        if (retire) begin
            complete(rob_id_t'(id + k));
            expect_commit(rd, dest + k, prev, 1);
        end
        prev = dest + k;
    end
endtask

task automatic flush_pipeline();
    flush = 1'b1;
    next_cycle();
    flush = 1'b0;
endtask

task automatic close_test();
    if (test_name.len() != 0) begin
        $display("test %s: %s with %0d errors", test_name,
                 (test_errors == 0) ? "passed" : "failed", test_errors);
        tests++;
        errors += test_errors;
    end
    test_errors = 0;
endtask

initial begin
    int    fd, n, a, b, c, d, e, f, g;
    string line, cmd;
    rst            = 1'b1;
    dispatch_valid = 1'b0;
    arch_rd        = '0;
    arch_rs1       = '0;
    arch_rs2       = '0;
    complete_valid = 1'b0;
    complete_id    = '0;
    flush          = 1'b0;
    checks         = 0;
    errors         = 0;
    test_errors    = 0;
    tests          = 0;
    aborted        = 1'b0;
    test_name      = "";
    void'($urandom(32'hc3c9));
    repeat (4) begin
        @(posedge clk);
    end
    #1;
    rst = 1'b0;
    fd = $fopen("sim/rename_patterns.txt", "r");
    if (fd == 0) begin
        $display("could not open sim/rename_patterns.txt");
        errors++;
    end else begin
        while (!$feof(fd) && !aborted) begin
            line = "";
            cmd  = "";
            n = $fgets(line, fd);
            n = $sscanf(line, "%s %d %d %d %d %d %d %d", cmd, a, b, c, d, e, f, g);
            if (cmd == "test") begin
                close_test();
                n = $sscanf(line, "%s %s", cmd, test_name);
            end else if (cmd == "disp") begin
                dispatch(a, b, c, d, e, f, g);
            end else if (cmd == "chain") begin
                dispatch_chain(a, b, c, d, e, 1'b0);
            end else if (cmd == "burst") begin
                dispatch_chain(a, b, c, d, e, 1'b1);
            end else if (cmd == "done") begin
                complete(a);
            end else if (cmd == "commit") begin
                expect_commit(a, b, c, d);
            end else if (cmd == "drop") begin
                dispatch_ignored(a, b, c);
            end else if (cmd == "full") begin
                check_value("rob_full", rob_full, a);
            end else if (cmd == "flush") begin
                flush_pipeline();
            end else if (cmd.len() != 0 && cmd[0] != "#") begin
                $display("unknown pattern command %s", cmd);
                test_errors++;
            end
        end
        $fclose(fd);
    end
    close_test();
    checks++;
    assert (rename_q.size() == 0 && commit_q.size() == 0) else begin
        $display("unexpected rename or commit output left over at end of run");
        errors++;
    end
    errors += rename_core_i.rename_core_sva_i.failures;
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
        $display("Regression passed");
    end else begin
        $display("Regression failed");
    end
    $finish;
end

endmodule : rename_core_tb

//--- sim/rename_patterns.txt
# disp rd rs1 rs2 exp_rs1 exp_rs2 exp_rd exp_id; chain/burst count rd src first_rd first_id
# done id; commit rd phys_rd freed_reg freed_valid; drop rd rs1 rs2; full flag; flush; test name
test reset_map
disp 1 2 3 2 3 32 0
disp 4 5 6 5 6 33 1
disp 7 8 9 8 9 34 2
test dependency
disp 5 1 4 32 33 35 3
disp 0 5 7 35 34 0 4
disp 2 0 5 0 35 36 5
test in_order_commit
done 4
done 1
done 0
commit 1 32 1 1
commit 4 33 4 1
done 3
done 2
commit 7 34 7 1
commit 5 35 5 1
commit 0 0 0 0
test full_buffer
chain 7 3 3 37 6
full 1
drop 6 6 3
done 5
commit 2 36 2 1
full 0
disp 6 6 3 6 43 44 5
full 1
test flush_recovery
done 6
done 7
commit 3 37 3 1
commit 3 38 37 1
flush
full 0
disp 8 3 2 38 36 39 0
disp 1 5 4 35 33 40 1
test recycling
done 0
done 1
commit 8 39 8 1
commit 1 40 32 1
burst 23 9 9 41 2
disp 10 9 1 63 40 1 1
disp 11 10 0 1 0 4 2
disp 12 11 8 4 39 7 3
done 1
done 2
done 3
commit 10 1 10 1
commit 11 4 11 1
commit 12 7 12 1

//--- sources.f
+incdir+design
design/rename_pkg.sv
design/rename_table.sv
design/free_list.sv
design/reorder_buffer.sv
design/retire_table.sv
design/rename_core.sv
sim/rename_core_sva.sv
sim/rename_core_tb.sv
